//--- Bender.yml
package:
  name: tensor_core

sources:
  - hw/tc_pkg.sv
  - hw/tc_dpu.sv
  - hw/tc_octet.sv
  - hw/tc_meta_queue.sv
  - hw/tc_writeback.sv
  - hw/tensor_core.sv
  - target: test
    files:
      - verif/tensor_core_assert.sv
      - verif/tensor_core_tb.sv

//--- hw/tc_dpu.sv
`timescale 1ns/1ps
`default_nettype none

module tc_dpu #(
    parameter int latency = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  tc_pkg::a_tile_t    a_tile,
    input  tc_pkg::b_tile_t    b_tile,
    input  tc_pkg::tile_t      c_tile,
    input  tc_pkg::wid_t       in_wid,
    output logic               out_valid,
    input  logic               out_ready,
    output tc_pkg::octet_res_t out
);
    import tc_pkg::*;

    tile_t       d_tile;
    logic        stall;
    logic [latency-1:0] valid_q;
    octet_res_t  stage_q [latency];

    // d = a*b + c with k = 2, wrapping at 32 bits
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                d_tile[r][c] = c_tile[r][c] + a_tile[r][0] * b_tile[0][c]
                             + a_tile[r][1] * b_tile[1][c];
            end
        end
    end

    // a full pipe with a blocked output holds every stage
    assign stall    = valid_q[latency-1] && !out_ready;
    assign in_ready = !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < latency; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_q[0].tile <= d_tile;
            stage_q[0].wid  <= in_wid;
            for (int i = 1; i < latency; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[latency-1];
    assign out       = stage_q[latency-1];

endmodule

`default_nettype wire

//--- hw/tc_meta_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tc_meta_queue #(
    parameter int depth = 6
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  push,
    input  tc_pkg::meta_t                         push_meta,
    input  logic                                  pop_valid,
    input  tc_pkg::wid_t                          pop_wid,
    output tc_pkg::meta_t [tc_pkg::num_warps-1:0] head,
    output logic                                  any_full
);
    import tc_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [num_warps-1:0] full;

    // one queue per warp so both beats of a pair find their own entries
    for (genvar w = 0; w < num_warps; w++) begin : g_warp
        meta_t            mem [depth];
        logic [ptr_w-1:0] wr_ptr;
        logic [ptr_w-1:0] rd_ptr;
        logic [cnt_w-1:0] count;
        logic             push_w;
        logic             pop_w;

        assign push_w = push && (push_meta.wid == wid_t'(w));
        assign pop_w  = pop_valid && (pop_wid == wid_t'(w));

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push_w) begin
                    wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop_w) begin
                    rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
                end
                if (push_w && !pop_w) begin
                    count <= count + 1'b1;
                end else if (pop_w && !push_w) begin
                    count <= count - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push_w) begin
                mem[wr_ptr] <= push_meta;
            end
        end

        assign head[w] = mem[rd_ptr];
        assign full[w] = (count == cnt_w'(depth));
    end

    // block dispatch if any single warp is out of room
    assign any_full = |full;

endmodule

`default_nettype wire

//--- hw/tc_octet.sv
`timescale 1ns/1ps
`default_nettype none

module tc_octet #(
    parameter int result_depth = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               op_valid,
    output logic               op_ready,
    input  tc_pkg::octet_in_t  op,
    output logic               res_valid,
    input  logic               res_ready,
    output tc_pkg::octet_res_t res
);
    import tc_pkg::*;

    localparam int ptr_w = (result_depth > 1) ? $clog2(result_depth) : 1;
    localparam int cnt_w = $clog2(result_depth + 1);

    // halves picked from the current substep
    data_t [3:0] a_half;
    data_t [3:0] b_half;
    octet_data_t c_half;

    // per-warp staging of the first substep of a pair
    data_t [3:0] a_stored [num_warps];
    data_t [3:0] b_stored [num_warps];
    octet_data_t c_stored [num_warps];

    a_tile_t    a_tile;
    b_tile_t    b_tile;
    tile_t      c_tile;
    logic       first_fire;
    logic       dpu_valid;
    logic       dpu_ready;
    octet_res_t dpu_res;

    octet_res_t        buf_q [result_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              buf_full;
    logic              buf_push;
    logic              buf_pop;

    // step bit 0 picks the A column pair, step bit 1 the B row
    always_comb begin
        if (op.step[0]) begin
            a_half = {op.a[7], op.a[6], op.a[3], op.a[2]};
        end else begin
            a_half = {op.a[5], op.a[4], op.a[1], op.a[0]};
        end
        b_half = op.step[1] ? op.b[7:4] : op.b[3:0];
        c_half = op.c;
    end

    assign first_fire = op_valid && op_ready && !op.last_in_pair;

    always_ff @(posedge clk) begin
        if (first_fire) begin
            a_stored[op.wid] <= a_half;
            b_stored[op.wid] <= b_half;
            c_stored[op.wid] <= c_half;
        end
    end

    // join stored half (even column / row 0) with the new half
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            a_tile[r][0] = a_stored[op.wid][r];
            a_tile[r][1] = a_half[r];
            for (int j = 0; j < 2; j++) begin
                c_tile[r][2*j]   = c_stored[op.wid][4*(r/2) + 2*j + (r%2)];
                c_tile[r][2*j+1] = c_half[4*(r/2) + 2*j + (r%2)];
            end
        end
        b_tile[0] = b_stored[op.wid];
        b_tile[1] = b_half;
    end

    tc_dpu #(
        .latency (3)
    ) dpu_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (op_valid && op.last_in_pair),
        .in_ready  (op_ready),
        .a_tile    (a_tile),
        .b_tile    (b_tile),
        .c_tile    (c_tile),
        .in_wid    (op.wid),
        .out_valid (dpu_valid),
        .out_ready (dpu_ready),
        .out       (dpu_res)
    );

    // result buffer absorbs commit back-pressure
    assign buf_full  = (count == cnt_w'(result_depth));
    assign dpu_ready = !buf_full;
    assign buf_push  = dpu_valid && !buf_full;
    assign res_valid = (count != '0);
    assign buf_pop   = res_valid && res_ready;
    assign res       = buf_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (buf_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(result_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (buf_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(result_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (buf_push && !buf_pop) begin
                count <= count + 1'b1;
            end else if (buf_pop && !buf_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buf_push) begin
            buf_q[wr_ptr] <= dpu_res;
        end
    end

endmodule

`default_nettype wire

//--- hw/tc_pkg.sv
`default_nettype none

package tc_pkg;

    // lane geometry of one warp
    localparam int num_lanes      = 16;
    localparam int num_warps      = 4;
    localparam int num_octets     = num_lanes / 8;
    // the two thread groups of an octet sit this many lanes apart
    localparam int lane_offset_tg = 8;

    typedef logic [31:0] data_t;
    typedef logic [1:0]  wid_t;
    typedef logic [1:0]  step_t;
    typedef logic [7:0]  uuid_t;
    typedef logic [4:0]  reg_t;
    typedef logic [31:0] pc_t;
    typedef logic [15:0] tmask_t;

    typedef data_t [num_lanes-1:0] lanes_t;
    typedef data_t [7:0]           octet_data_t;
    typedef data_t [3:0][3:0]      tile_t;
    // row-major 4x2 and 2x4 operand tiles
    typedef data_t [3:0][1:0]      a_tile_t;
    typedef data_t [1:0][3:0]      b_tile_t;

    typedef struct packed {
        octet_data_t a;
        octet_data_t b;
        octet_data_t c;
        wid_t        wid;
        step_t       step;
        logic        last_in_pair;
    } octet_in_t;

    typedef struct packed {
        tile_t tile;
        wid_t  wid;
    } octet_res_t;

    // 64 bits of commit metadata
    typedef struct packed {
        uuid_t  uuid;
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
        logic   wb;
        reg_t   rd;
    } meta_t;

    typedef struct packed {
        meta_t  meta;
        lanes_t rs1;
        lanes_t rs2;
        lanes_t rs3;
        step_t  step;
        logic   last_in_pair;
    } dispatch_t;

    typedef struct packed {
        meta_t  meta;
        lanes_t data;
    } commit_t;

endpackage

`default_nettype wire

//--- hw/tc_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module tc_writeback (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [tc_pkg::num_octets-1:0]               res_valid,
    input  tc_pkg::octet_res_t [tc_pkg::num_octets-1:0] res,
    output logic                                        res_ready,
    input  tc_pkg::meta_t [tc_pkg::num_warps-1:0]       head,
    output logic                                        pop_valid,
    output tc_pkg::wid_t                                pop_wid,
    output logic                                        commit_valid,
    input  logic                                        commit_ready,
    output tc_pkg::commit_t                             commit
);
    import tc_pkg::*;

    logic beat;
    logic fire;
    wid_t wid;

    // octets run in lockstep, so octet 0 names the warp
    assign wid          = res[0].wid;
    assign commit_valid = &res_valid;
    assign fire         = commit_valid && commit_ready;

    // each beat pops one queue entry, one per substep of the pair
    assign pop_valid = fire;
    assign pop_wid   = wid;

    // release the result tiles once the second beat leaves
    assign res_ready = fire && beat;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat <= 1'b0;
        end else if (fire) begin
            beat <= !beat;
        end
    end

    // 8 lanes per octet carry half of the 4x4 tile per beat
    // beat 0 holds columns 0 and 2, beat 1 columns 1 and 3
    always_comb begin
        commit.meta = head[wid];
        for (int i = 0; i < num_octets; i++) begin
            for (int g = 0; g < 2; g++) begin
                for (int k = 0; k < 2; k++) begin
                    for (int q = 0; q < 2; q++) begin
                        commit.data[4*i + lane_offset_tg*g + 2*k + q] =
                            res[i].tile[2*g + q][2*k + int'(beat)];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/tensor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_core #(
    parameter int meta_depth   = 6,
    parameter int result_depth = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    input  tc_pkg::dispatch_t dispatch,
    output logic              commit_valid,
    input  logic              commit_ready,
    output tc_pkg::commit_t   commit
);
    import tc_pkg::*;

    logic                  ready_en;
    logic                  any_full;
    logic                  op_fire;
    logic [num_octets-1:0] operands_ready;
    logic [num_octets-1:0] res_valid;
    octet_res_t [num_octets-1:0] res;
    logic                  res_ready;
    meta_t [num_warps-1:0] head;
    logic                  pop_valid;
    wid_t                  pop_wid;

    // hold off dispatch for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    assign dispatch_ready = ready_en && (&operands_ready) && !any_full;
    // octets and the metadata queue see the same accept
    assign op_fire = dispatch_valid && dispatch_ready;

    for (genvar i = 0; i < num_octets; i++) begin : g_octet
        octet_in_t op;

        // thread group 0 takes lanes 4i.., thread group 1 the lanes 8 above
        assign op.a            = {dispatch.rs1[lane_offset_tg + 4*i +: 4], dispatch.rs1[4*i +: 4]};
        assign op.b            = {dispatch.rs2[lane_offset_tg + 4*i +: 4], dispatch.rs2[4*i +: 4]};
        assign op.c            = {dispatch.rs3[lane_offset_tg + 4*i +: 4], dispatch.rs3[4*i +: 4]};
        assign op.wid          = dispatch.meta.wid;
        assign op.step         = dispatch.step;
        assign op.last_in_pair = dispatch.last_in_pair;

        tc_octet #(
            .result_depth (result_depth)
        ) octet_i (
            .clk       (clk),
            .reset     (reset),
            .op_valid  (op_fire),
            .op_ready  (operands_ready[i]),
            .op        (op),
            .res_valid (res_valid[i]),
            .res_ready (res_ready),
            .res       (res[i])
        );
    end

    tc_meta_queue #(
        .depth (meta_depth)
    ) meta_queue_i (
        .clk       (clk),
        .reset     (reset),
        .push      (op_fire),
        .push_meta (dispatch.meta),
        .pop_valid (pop_valid),
        .pop_wid   (pop_wid),
        .head      (head),
        .any_full  (any_full)
    );

    tc_writeback writeback_i (
        .clk          (clk),
        .reset        (reset),
        .res_valid    (res_valid),
        .res          (res),
        .res_ready    (res_ready),
        .head         (head),
        .pop_valid    (pop_valid),
        .pop_wid      (pop_wid),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

`default_nettype wire

//--- project.f
hw/tc_pkg.sv
hw/tc_dpu.sv
hw/tc_octet.sv
hw/tc_meta_queue.sv
hw/tc_writeback.sv
hw/tensor_core.sv
verif/tensor_core_assert.sv
verif/tensor_core_tb.sv

//--- verif/tensor_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_core_assert (
    input logic              clk,
    input logic              reset,
    input logic              dispatch_valid,
    input logic              dispatch_ready,
    input tc_pkg::dispatch_t dispatch,
    input logic              commit_valid,
    input logic              commit_ready,
    input tc_pkg::commit_t   commit
);
    int error_count = 0;

    // a stalled beat stays on the bus until it is taken
    commit_stable: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
    else begin
        error_count++;
        $error("commit changed while stalled");
    end

    // a substep not taken stays pending on the dispatch bus
    dispatch_held: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch))
    else begin
        error_count++;
        $error("substep dropped or changed with dispatch_ready low");
    end

    no_commit_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !commit_valid)
    else begin
        error_count++;
        $error("commit_valid high right after reset");
    end

endmodule

bind tensor_core tensor_core_assert tensor_core_assert_i (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch       (dispatch),
    .commit_valid   (commit_valid),
    .commit_ready   (commit_ready),
    .commit         (commit)
);

`default_nettype wire

//--- verif/tensor_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_core_tb;
    import tc_pkg::*;

    localparam int wait_limit   = 2000;
    localparam int random_pairs = 200;

    logic      clk;
    logic      reset;
    logic      dispatch_valid;
    logic      dispatch_ready;
    dispatch_t dispatch;
    logic      commit_valid;
    logic      commit_ready;
    commit_t   commit;

    integer seed;
    integer ready_seed;
    // 0 always ready, 1 held low, 2 random
    int     ready_mode;
    int     errors;
    int     beats_checked;
    int     pairs_sent;
    int     tests_run;
    int     tests_bad;
    int     uuid_ctr;
    logic   timed_out;

    // expected beats in the order the last substeps went in
    commit_t exp_q [$];
    data_t   st_a [num_warps][num_octets][4];
    data_t   st_b [num_warps][num_octets][4];
    data_t   st_c [num_warps][num_octets][8];
    meta_t   st_meta [num_warps];

    tensor_core tensor_core_i (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch       (dispatch),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit         (commit)
    );

    always #20 clk = ~clk;

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got.meta !== exp.meta) begin
            errors++;
            $display("[ERROR] time %0d ns: uuid %h meta %h, expected meta %h",
                     $time, exp.meta.uuid, got.meta, exp.meta);
        end
        for (int l = 0; l < num_lanes; l++) begin
            if (got.data[l] !== exp.data[l]) begin
                errors++;
                $display("[ERROR] time %0d ns: uuid %h lane %0d is %h, expected %h",
                         $time, exp.meta.uuid, l, got.data[l], exp.data[l]);
            end
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] time %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("[ERROR] time %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        $display("timeout: no progress after %0d cycles while waiting for %s", wait_limit, what);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before && !timed_out) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    // octet lanes 0..3 from thread group 0, lanes 4..7 from thread group 1
    function automatic data_t octet_lane(input lanes_t src, input int oct, input int l);
        if (l < 4) begin
            return src[4*oct + l];
        end
        return src[lane_offset_tg + 4*oct + l - 4];
    endfunction

    // odd steps take the upper column pair of each thread group
    function automatic data_t a_pick(input lanes_t src, input int oct, input step_t step,
                                     input int k);
        return octet_lane(src, oct, (step[0] ? 2 : 0) + (k % 2) + 4 * (k / 2));
    endfunction

    function automatic data_t b_pick(input lanes_t src, input int oct, input step_t step,
                                     input int k);
        return octet_lane(src, oct, (step[1] ? 4 : 0) + k);
    endfunction

    function automatic void model_accept(input dispatch_t d);
        int      w;
        data_t   a [4][2];
        data_t   b [2][4];
        data_t   c [4][4];
        data_t   dt [num_octets][4][4];
        commit_t beat [2];
        w = int'(d.meta.wid);
        if (!d.last_in_pair) begin
            for (int o = 0; o < num_octets; o++) begin
                for (int k = 0; k < 4; k++) begin
                    st_a[w][o][k] = a_pick(d.rs1, o, d.step, k);
                    st_b[w][o][k] = b_pick(d.rs2, o, d.step, k);
                end
                for (int e = 0; e < 8; e++) begin
                    st_c[w][o][e] = octet_lane(d.rs3, o, e);
                end
            end
            st_meta[w] = d.meta;
        end else begin
            for (int o = 0; o < num_octets; o++) begin
                for (int k = 0; k < 4; k++) begin
                    a[k][0] = st_a[w][o][k];
                    a[k][1] = a_pick(d.rs1, o, d.step, k);
                    b[0][k] = st_b[w][o][k];
                    b[1][k] = b_pick(d.rs2, o, d.step, k);
                end
                // c element e lands in row 2*(e/4)+e%2, column pair (e%4)/2
                for (int e = 0; e < 8; e++) begin
                    c[2*(e/4) + e%2][2*((e%4)/2)]     = st_c[w][o][e];
                    c[2*(e/4) + e%2][2*((e%4)/2) + 1] = octet_lane(d.rs3, o, e);
                end
                for (int r = 0; r < 4; r++) begin
                    for (int col = 0; col < 4; col++) begin
                        dt[o][r][col] = c[r][col] + a[r][0] * b[0][col] + a[r][1] * b[1][col];
                    end
                end
            end
            beat[0].meta = st_meta[w];
            beat[1].meta = d.meta;
            for (int h = 0; h < 2; h++) begin
                for (int o = 0; o < num_octets; o++) begin
                    for (int g = 0; g < 2; g++) begin
                        beat[h].data[4*o + 8*g + 0] = dt[o][2*g][h];
                        beat[h].data[4*o + 8*g + 1] = dt[o][2*g + 1][h];
                        beat[h].data[4*o + 8*g + 2] = dt[o][2*g][2 + h];
                        beat[h].data[4*o + 8*g + 3] = dt[o][2*g + 1][2 + h];
                    end
                end
            end
            exp_q.push_back(beat[0]);
            exp_q.push_back(beat[1]);
        end
    endfunction

    function automatic dispatch_t make_substep(input int w, input logic last, input step_t step);
        dispatch_t d;
        d.meta.uuid  = uuid_t'(uuid_ctr);
        d.meta.wid   = wid_t'(w);
        d.meta.tmask = tmask_t'($random(seed));
        d.meta.pc    = pc_t'($random(seed));
        d.meta.wb    = 1'b1;
        d.meta.rd    = reg_t'($random(seed));
        for (int l = 0; l < num_lanes; l++) begin
            d.rs1[l] = data_t'($random(seed));
            d.rs2[l] = data_t'($random(seed));
            d.rs3[l] = data_t'($random(seed));
        end
        d.step         = step;
        d.last_in_pair = last;
        uuid_ctr++;
        return d;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_substep(input dispatch_t d);
        int waited;
        waited = 0;
        if (!timed_out) begin
            dispatch       = d;
            dispatch_valid = 1'b1;
            while (!dispatch_ready && waited < wait_limit) begin
                @(negedge clk);
                waited++;
            end
            if (!dispatch_ready) begin
                note_timeout("dispatch_ready to take a substep");
            end else begin
                @(posedge clk);
                model_accept(d);
                @(negedge clk);
            end
            dispatch_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            note_timeout("the outstanding commit beats");
        end
    endtask

    // commit side: drive ready, then check the beat that the next edge takes
    always @(negedge clk) begin
        commit_t exp;
        case (ready_mode)
            0:       commit_ready = 1'b1;
            1:       commit_ready = 1'b0;
            default: commit_ready = ($random(ready_seed) % 4) != 0;
        endcase
        if (!reset && commit_valid === 1'b1 && commit_ready) begin
            beats_checked++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("[ERROR] time %0d ns: commit for warp %0d with no beat outstanding",
                         $time, commit.meta.wid);
            end else begin
                exp = exp_q.pop_front();
                check_commit(commit, exp);
            end
        end
    end

    task automatic test_after_reset();
        int e0;
        int waited;
        e0     = errors;
        waited = 0;
        check_ready(commit_valid, 1'b0, "commit_valid after reset");
        while (!dispatch_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        check_ready(dispatch_ready, 1'b1, "dispatch_ready after reset");
        report_test("reset state", e0);
    endtask

    task automatic test_single_pair();
        int e0;
        int b0;
        e0 = errors;
        b0 = beats_checked;
        for (int s = 0; s < 4; s++) begin
            send_substep(make_substep(0, 1'b0, step_t'(s)));
            send_substep(make_substep(0, 1'b1, step_t'(s)));
            pairs_sent++;
        end
        wait_drain();
        check_count(beats_checked - b0, 8, "beats for warp 0 pairs");
        report_test("single pair per step", e0);
    endtask

    task automatic test_interleaved();
        int e0;
        int b0;
        e0 = errors;
        b0 = beats_checked;
        for (int round = 0; round < 2; round++) begin
            for (int w = 0; w < num_warps; w++) begin
                send_substep(make_substep(w, 1'b0, step_t'($random(seed))));
            end
            // finish in reverse so completion order differs from start order
            for (int w = num_warps - 1; w >= 0; w--) begin
                send_substep(make_substep(w, 1'b1, step_t'($random(seed))));
                pairs_sent++;
            end
        end
        wait_drain();
        check_count(beats_checked - b0, 4 * num_warps, "beats for interleaved warps");
        report_test("interleaved warps", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int b0;
        int waited;
        e0         = errors;
        b0         = beats_checked;
        waited     = 0;
        ready_mode = 1;
        @(negedge clk);
        for (int p = 0; p < 3; p++) begin
            send_substep(make_substep(1, 1'b0, step_t'($random(seed))));
            send_substep(make_substep(1, 1'b1, step_t'($random(seed))));
            pairs_sent++;
        end
        while (dispatch_ready && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        check_ready(dispatch_ready, 1'b0, "dispatch_ready with commit stalled");
        repeat (20) @(negedge clk);
        check_ready(commit_valid, 1'b1, "commit_valid while stalled");
        // the stalled beat is the oldest one still expected
        check_commit(commit, exp_q[0]);
        ready_mode = 0;
        wait_drain();
        repeat (10) @(negedge clk);
        check_ready(commit_valid, 1'b0, "commit_valid after drain");
        check_count(beats_checked - b0, 6, "beats after release");
        report_test("commit back-pressure", e0);
    endtask

    task automatic test_random();
        int                   e0;
        int                   b0;
        int                   w;
        int                   started;
        int                   finished;
        int                   guard;
        logic [num_warps-1:0] pending;
        e0         = errors;
        b0         = beats_checked;
        started    = 0;
        finished   = 0;
        guard      = 0;
        pending    = '0;
        ready_mode = 2;
        while ((started < random_pairs || pending != '0) && !timed_out && guard < 100000) begin
            w = $random(seed) & 3;
            if (pending[w]) begin
                send_substep(make_substep(w, 1'b1, step_t'($random(seed))));
                pending[w] = 1'b0;
                finished++;
            end else if (started < random_pairs) begin
                send_substep(make_substep(w, 1'b0, step_t'($random(seed))));
                pending[w] = 1'b1;
                started++;
            end
            if (($random(seed) & 7) == 0) begin
                @(negedge clk);
            end
            guard++;
        end
        pairs_sent += finished;
        wait_drain();
        ready_mode = 0;
        check_count(finished, random_pairs, "random pairs dispatched");
        check_count(beats_checked - b0, 2 * finished, "random beats checked");
        report_test("random run", e0);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        commit_ready   = 1'b1;
        seed           = 32'h9e4e;
        ready_seed     = 32'h9e4e ^ 32'h3c3c;
        ready_mode     = 0;
        errors         = 0;
        beats_checked  = 0;
        pairs_sent     = 0;
        tests_run      = 0;
        tests_bad      = 0;
        uuid_ctr       = 0;
        timed_out      = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_after_reset();
        if (!timed_out) test_single_pair();
        if (!timed_out) test_interleaved();
        if (!timed_out) test_backpressure();
        if (!timed_out) test_random();

        if (tensor_core_i.tensor_core_assert_i.error_count != 0) begin
            errors += tensor_core_i.tensor_core_assert_i.error_count;
            $display("bound assertions reported %0d failures",
                     tensor_core_i.tensor_core_assert_i.error_count);
        end
        $display("summary: %0d tests run, %0d with errors, %0d pairs, %0d beats, %0d errors",
                 tests_run, tests_bad, pairs_sent, beats_checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
